// ==== rtl/rename_cfg.svh ====
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// instructions renamed per group
`define RN_SLOTS 4

// register index widths
`define RN_AREG_W 5
`define RN_PREG_W 6

// RAT depth, one entry per architectural register
`define RN_NUM_AREG 32

// r0 is hardwired and never gets a physical register
`define RN_ZERO_AREG 0

`endif

// ==== rtl/rename_arch_pkg.sv ====
`include "rename_cfg.svh"

package rename_arch_pkg;

    // architectural register index, as decoded from the instruction
    typedef logic [`RN_AREG_W-1:0] areg_t;

    // physical register index, as held in the RAT and the free list
    typedef logic [`RN_PREG_W-1:0] preg_t;

endpackage

// ==== rtl/rename_ctrl_pkg.sv ====
`include "rename_cfg.svh"

package rename_ctrl_pkg;

    typedef logic [`RN_SLOTS-1:0] slot_mask_t;   // bit 0 is the oldest slot

    typedef logic [$clog2(`RN_SLOTS+1)-1:0] pr_count_t;   // 0..RN_SLOTS

    typedef logic [5:0] room_t;   // free-list room

endpackage

// ==== rtl/rename_alloc.sv ====
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rename_alloc
    import rename_arch_pkg::*;
    import rename_ctrl_pkg::*;
(
    input  slot_mask_t                 dec_vld,
    input  slot_mask_t                 dec_dest_vld,
    input  areg_t [`RN_SLOTS-1:0]      dec_dest_areg,
    input  preg_t [`RN_SLOTS-1:0]      free_preg,
    input  room_t                      freelist_room,
    input  logic                       flush,
    input  logic                       hold,
    output slot_mask_t                 alloc_en,
    output slot_mask_t                 rat_wr_en,
    output preg_t [`RN_SLOTS-1:0]      dest_preg,
    output pr_count_t                  pr_num_need,
    output logic                       pause
);

    pr_count_t alloc_cnt;

    always_comb begin
        for (int i = 0; i < `RN_SLOTS; i++) begin
            alloc_en[i] = dec_vld[i] && dec_dest_vld[i] &&
                          (dec_dest_areg[i] != areg_t'(`RN_ZERO_AREG));
        end
    end

    // free registers are handed out in slot order
    always_comb begin
        pr_count_t older;
        older = '0;
        for (int i = 0; i < `RN_SLOTS; i++) begin
            dest_preg[i] = '0;
            if (alloc_en[i]) begin
                dest_preg[i] = free_preg[older];   // skips non-allocating slots
                older        = older + 1'b1;
            end
        end
        alloc_cnt = older;
    end

    assign pr_num_need = (flush || hold) ? '0 : alloc_cnt;

    assign pause = room_t'(pr_num_need) > freelist_room;

    // only the youngest writer of an areg updates the RAT
    always_comb begin
        for (int i = 0; i < `RN_SLOTS; i++) begin
            rat_wr_en[i] = alloc_en[i];
            for (int j = i + 1; j < `RN_SLOTS; j++) begin
                if (alloc_en[j] && (dec_dest_areg[j] == dec_dest_areg[i])) begin
                    rat_wr_en[i] = 1'b0;
                end
            end
        end
    end

    // duplicates here mean the free list offered the same preg twice
    always_comb begin
        for (int i = 0; i < `RN_SLOTS; i++) begin
            for (int j = i + 1; j < `RN_SLOTS; j++) begin
                if (alloc_en[i] && alloc_en[j]) begin
                    assert final (dest_preg[i] != dest_preg[j])
                        else $error("rename_alloc: slots %0d and %0d share preg %0d",
                                    i, j, dest_preg[i]);
                end
            end
        end
    end

endmodule

// ==== rtl/rename_lookup.sv ====
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rename_lookup
    import rename_arch_pkg::*;
    import rename_ctrl_pkg::*;
(
    input  slot_mask_t                   dec_vld,
    input  slot_mask_t                   dec_dest_vld,
    input  slot_mask_t                   dec_src1_vld,
    input  slot_mask_t                   dec_src2_vld,
    input  areg_t [`RN_SLOTS-1:0]        dec_dest_areg,
    input  areg_t [`RN_SLOTS-1:0]        dec_src1_areg,
    input  areg_t [`RN_SLOTS-1:0]        dec_src2_areg,
    input  preg_t [`RN_NUM_AREG-1:0]     rat_map,
    input  slot_mask_t                   alloc_en,
    input  preg_t [`RN_SLOTS-1:0]        dest_preg,
    output preg_t [`RN_SLOTS-1:0]        src1_preg,
    output preg_t [`RN_SLOTS-1:0]        src2_preg,
    output preg_t [`RN_SLOTS-1:0]        old_preg,
    output slot_mask_t                   dest_load,
    output slot_mask_t                   src1_load,
    output slot_mask_t                   src2_load,
    output slot_mask_t                   src1_en,
    output slot_mask_t                   src2_en
);

    // source mapping, RAT first, then overridden by older in-group writers
    always_comb begin
        for (int i = 0; i < `RN_SLOTS; i++) begin
            src1_preg[i] = rat_map[dec_src1_areg[i]];
            src2_preg[i] = rat_map[dec_src2_areg[i]];
            // later j wins, so the youngest older writer is taken
            for (int j = 0; j < i; j++) begin
                if (alloc_en[j] && (dec_dest_areg[j] == dec_src1_areg[i])) begin
                    src1_preg[i] = dest_preg[j];
                end
                if (alloc_en[j] && (dec_dest_areg[j] == dec_src2_areg[i])) begin
                    src2_preg[i] = dest_preg[j];
                end
            end
        end
    end

    // previous mapping of the destination, no in-group bypass
    always_comb begin
        for (int i = 0; i < `RN_SLOTS; i++) begin
            old_preg[i] = rat_map[dec_dest_areg[i]];
        end
    end

    assign dest_load = dec_vld & dec_dest_vld;   // dest and old preg
    assign src1_load = dec_vld & dec_src1_vld;
    assign src2_load = dec_vld & dec_src2_vld;

    assign src1_en = dec_vld & dec_src1_vld;   // reloaded every cycle
    assign src2_en = dec_vld & dec_src2_vld;

endmodule

// ==== rtl/rename_stage_reg.sv ====
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rename_stage_reg
    import rename_ctrl_pkg::*;
#(
    parameter type payload_t = logic
)(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush,
    input  logic                        hold,
    input  slot_mask_t                  load,
    input  payload_t [`RN_SLOTS-1:0]    d,
    output payload_t [`RN_SLOTS-1:0]    q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;   // flush beats hold
        end else if (!hold) begin
            for (int i = 0; i < `RN_SLOTS; i++) begin
                if (load[i]) begin
                    q[i] <= d[i];
                end
            end
        end
    end

    // a flushed group must never leak into stage 4
    flush_clears_q: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> (q == '0))
        else $error("rename_stage_reg: q not cleared after flush");

endmodule

// ==== rtl/rename_top.sv ====
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rename_top
    import rename_arch_pkg::*;
    import rename_ctrl_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         flush,
    input  logic                         hold,

    input  slot_mask_t                   dec_vld,
    input  slot_mask_t                   dec_dest_vld,
    input  slot_mask_t                   dec_src1_vld,
    input  slot_mask_t                   dec_src2_vld,
    input  areg_t [`RN_SLOTS-1:0]        dec_dest_areg,
    input  areg_t [`RN_SLOTS-1:0]        dec_src1_areg,
    input  areg_t [`RN_SLOTS-1:0]        dec_src2_areg,

    input  preg_t [`RN_SLOTS-1:0]        free_preg,
    input  room_t                        freelist_room,
    input  preg_t [`RN_NUM_AREG-1:0]     rat_map,

    output pr_count_t                    pr_num_need,
    output logic                         pause,
    output slot_mask_t                   alloc_en,
    output slot_mask_t                   rat_wr_en,
    output preg_t [`RN_SLOTS-1:0]        dest_preg,

    output preg_t [`RN_SLOTS-1:0]        s4_dest_preg,
    output preg_t [`RN_SLOTS-1:0]        s4_old_preg,
    output preg_t [`RN_SLOTS-1:0]        s4_src1_preg,
    output preg_t [`RN_SLOTS-1:0]        s4_src2_preg,
    output slot_mask_t                   s4_src1_en,
    output slot_mask_t                   s4_src2_en
);

    preg_t [`RN_SLOTS-1:0] src1_preg;
    preg_t [`RN_SLOTS-1:0] src2_preg;
    preg_t [`RN_SLOTS-1:0] old_preg;
    slot_mask_t            dest_load;
    slot_mask_t            src1_load;
    slot_mask_t            src2_load;
    slot_mask_t            src1_en;
    slot_mask_t            src2_en;

    rename_alloc u_alloc (
        .dec_vld        (dec_vld),
        .dec_dest_vld   (dec_dest_vld),
        .dec_dest_areg  (dec_dest_areg),
        .free_preg      (free_preg),
        .freelist_room  (freelist_room),
        .flush          (flush),
        .hold           (hold),
        .alloc_en       (alloc_en),
        .rat_wr_en      (rat_wr_en),
        .dest_preg      (dest_preg),
        .pr_num_need    (pr_num_need),
        .pause          (pause)
    );

    rename_lookup u_lookup (
        .dec_vld        (dec_vld),
        .dec_dest_vld   (dec_dest_vld),
        .dec_src1_vld   (dec_src1_vld),
        .dec_src2_vld   (dec_src2_vld),
        .dec_dest_areg  (dec_dest_areg),
        .dec_src1_areg  (dec_src1_areg),
        .dec_src2_areg  (dec_src2_areg),
        .rat_map        (rat_map),
        .alloc_en       (alloc_en),
        .dest_preg      (dest_preg),
        .src1_preg      (src1_preg),
        .src2_preg      (src2_preg),
        .old_preg       (old_preg),
        .dest_load      (dest_load),
        .src1_load      (src1_load),
        .src2_load      (src2_load),
        .src1_en        (src1_en),
        .src2_en        (src2_en)
    );

    rename_stage_reg #(.payload_t(preg_t)) u_s4_dest (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .hold  (hold),
        .load  (dest_load),
        .d     (dest_preg),
        .q     (s4_dest_preg)
    );

    rename_stage_reg #(.payload_t(preg_t)) u_s4_old (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .hold  (hold),
        .load  (dest_load),   // same strobe as the new dest
        .d     (old_preg),
        .q     (s4_old_preg)
    );

    rename_stage_reg #(.payload_t(preg_t)) u_s4_src1 (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .hold  (hold),
        .load  (src1_load),
        .d     (src1_preg),
        .q     (s4_src1_preg)
    );

    rename_stage_reg #(.payload_t(preg_t)) u_s4_src2 (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .hold  (hold),
        .load  (src2_load),
        .d     (src2_preg),
        .q     (s4_src2_preg)
    );

    rename_stage_reg #(.payload_t(logic)) u_s4_src1_en (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .hold  (hold),
        .load  ({`RN_SLOTS{1'b1}}),   // enables reload each cycle
        .d     (src1_en),
        .q     (s4_src1_en)
    );

    rename_stage_reg #(.payload_t(logic)) u_s4_src2_en (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .hold  (hold),
        .load  ({`RN_SLOTS{1'b1}}),
        .d     (src2_en),
        .q     (s4_src2_en)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
)(
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(PERIOD_NS / 10);   // release away from the edge
        rst_n = 1'b1;
    end

endmodule

// ==== tb/rename_tb.sv ====
`timescale 1ns/1ps
`include "rename_cfg.svh"

module rename_tb
    import rename_arch_pkg::*;
    import rename_ctrl_pkg::*;
();

    localparam int          NUM_CYCLES     = 2000;
    localparam int          TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 20;
    localparam logic [15:0] LFSR_SEED      = 16'd29329;

    logic                     clk;
    logic                     rst_n;
    logic                     flush;
    logic                     hold;
    slot_mask_t               dec_vld;
    slot_mask_t               dec_dest_vld;
    slot_mask_t               dec_src1_vld;
    slot_mask_t               dec_src2_vld;
    areg_t [`RN_SLOTS-1:0]    dec_dest_areg;
    areg_t [`RN_SLOTS-1:0]    dec_src1_areg;
    areg_t [`RN_SLOTS-1:0]    dec_src2_areg;
    preg_t [`RN_SLOTS-1:0]    free_preg;
    room_t                    freelist_room;
    preg_t [`RN_NUM_AREG-1:0] rat_map;

    pr_count_t                pr_num_need;
    logic                     pause;
    slot_mask_t               alloc_en;
    slot_mask_t               rat_wr_en;
    preg_t [`RN_SLOTS-1:0]    dest_preg;
    preg_t [`RN_SLOTS-1:0]    s4_dest_preg;
    preg_t [`RN_SLOTS-1:0]    s4_old_preg;
    preg_t [`RN_SLOTS-1:0]    s4_src1_preg;
    preg_t [`RN_SLOTS-1:0]    s4_src2_preg;
    slot_mask_t               s4_src1_en;
    slot_mask_t               s4_src2_en;

    // reference model state
    slot_mask_t               exp_alloc;
    slot_mask_t               exp_wr;
    pr_count_t                exp_need;
    logic                     exp_pause;
    preg_t [`RN_SLOTS-1:0]    exp_dest;
    preg_t [`RN_SLOTS-1:0]    exp_old;
    preg_t [`RN_SLOTS-1:0]    exp_src1;
    preg_t [`RN_SLOTS-1:0]    exp_src2;
    preg_t [`RN_SLOTS-1:0]    sh_dest;   // shadow of stage 4
    preg_t [`RN_SLOTS-1:0]    sh_old;
    preg_t [`RN_SLOTS-1:0]    sh_src1;
    preg_t [`RN_SLOTS-1:0]    sh_src2;
    slot_mask_t               sh_src1_en;
    slot_mask_t               sh_src2_en;

    logic [15:0] lfsr_state;
    int          cycle_cnt   = 0;
    int          error_count = 0;
    int          n_flush     = 0;
    int          n_hold      = 0;
    int          n_pause     = 0;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(5)) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rename_top i_dut (
        .clk (clk), .rst_n (rst_n), .flush (flush), .hold (hold),
        .dec_vld (dec_vld), .dec_dest_vld (dec_dest_vld),
        .dec_src1_vld (dec_src1_vld), .dec_src2_vld (dec_src2_vld),
        .dec_dest_areg (dec_dest_areg), .dec_src1_areg (dec_src1_areg),
        .dec_src2_areg (dec_src2_areg), .free_preg (free_preg),
        .freelist_room (freelist_room), .rat_map (rat_map),
        .pr_num_need (pr_num_need), .pause (pause), .alloc_en (alloc_en),
        .rat_wr_en (rat_wr_en), .dest_preg (dest_preg),
        .s4_dest_preg (s4_dest_preg), .s4_old_preg (s4_old_preg),
        .s4_src1_preg (s4_src1_preg), .s4_src2_preg (s4_src2_preg),
        .s4_src1_en (s4_src1_en), .s4_src2_en (s4_src2_en)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];   // x^16 + x^14 + x^13 + x^11
        return {s[14:0], fb};
    endfunction

    task automatic draw(input int nbits, output logic [31:0] val);
        val = '0;
        for (int b = 0; b < nbits; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic fail_run(input string msg);
        error_count++;
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        fail_run($sformatf("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h",
                           $time, what, got, exp));
    endtask

    // a slot needs a new preg when valid, dest valid and not r0
    function automatic slot_mask_t alloc_mask(input slot_mask_t v, input slot_mask_t dv,
                                              input areg_t [`RN_SLOTS-1:0] d);
        slot_mask_t m;
        for (int i = 0; i < `RN_SLOTS; i++) begin
            m[i] = v[i] && dv[i] && (int'(d[i]) != `RN_ZERO_AREG);
        end
        return m;
    endfunction

    // youngest older allocating writer wins, else the RAT
    function automatic preg_t map_source(input int slot, input areg_t src);
        for (int j = slot - 1; j >= 0; j--) begin
            if (exp_alloc[j] && dec_dest_areg[j] == src) begin
                return exp_dest[j];
            end
        end
        return rat_map[src];
    endfunction

    task automatic drive_inputs();
        logic [31:0] r;
        int          nbits;
        logic [5:0]  base;
        logic [5:0]  step;
        draw(1, r);
        nbits = r[0] ? 2 : 5;   // narrow range forces collisions
        draw(4, r); dec_vld      = r[3:0];
        draw(4, r); dec_dest_vld = r[3:0];
        draw(4, r); dec_src1_vld = r[3:0];
        draw(4, r); dec_src2_vld = r[3:0];
        for (int i = 0; i < `RN_SLOTS; i++) begin
            draw(nbits, r); dec_dest_areg[i] = areg_t'(r);
            draw(nbits, r); dec_src1_areg[i] = areg_t'(r);
            draw(nbits, r); dec_src2_areg[i] = areg_t'(r);
        end
        draw(6, r); base = r[5:0];
        draw(3, r); step = {2'b00, r[2:0], 1'b1};   // odd step keeps pregs distinct
        for (int i = 0; i < `RN_SLOTS; i++) begin
            free_preg[i] = preg_t'(base + step * i);
        end
        draw(1, r);
        draw(r[0] ? 3 : 6, r);
        freelist_room = room_t'(r);
        for (int k = 0; k < `RN_NUM_AREG; k++) begin
            draw(6, r); rat_map[k] = preg_t'(r);
        end
        draw(4, r); flush = (r[3:0] == 4'd0);
        draw(3, r); hold  = (r[2:0] == 3'd0);
        if (!flush && $countones(alloc_mask(dec_vld, dec_dest_vld, dec_dest_areg)) >
            int'(freelist_room)) begin
            hold = 1'b1;   // environment turns pause into hold
            n_pause++;
        end
        n_flush += int'(flush);
        n_hold  += int'(hold);
    endtask

    task automatic compute_expected();
        int older;
        int total;
        exp_alloc = alloc_mask(dec_vld, dec_dest_vld, dec_dest_areg);
        total = 0;
        for (int i = 0; i < `RN_SLOTS; i++) begin
            older = 0;
            for (int j = 0; j < i; j++) begin
                older = older + int'(exp_alloc[j]);
            end
            exp_dest[i] = exp_alloc[i] ? free_preg[older] : '0;
            total = total + int'(exp_alloc[i]);
            exp_wr[i] = exp_alloc[i];
            for (int j = i + 1; j < `RN_SLOTS; j++) begin
                if (exp_alloc[j] && dec_dest_areg[j] == dec_dest_areg[i]) begin
                    exp_wr[i] = 1'b0;
                end
            end
            exp_old[i] = rat_map[dec_dest_areg[i]];
        end
        for (int i = 0; i < `RN_SLOTS; i++) begin
            exp_src1[i] = map_source(i, dec_src1_areg[i]);
            exp_src2[i] = map_source(i, dec_src2_areg[i]);
        end
        exp_need  = (flush || hold) ? '0 : pr_count_t'(total);
        exp_pause = int'(exp_need) > int'(freelist_room);
    endtask

    task automatic update_shadow();
        if (flush) begin
            sh_dest = '0; sh_old = '0; sh_src1 = '0; sh_src2 = '0;
            sh_src1_en = '0; sh_src2_en = '0;
        end else if (!hold) begin
            for (int i = 0; i < `RN_SLOTS; i++) begin
                if (dec_vld[i] && dec_dest_vld[i]) begin
                    sh_dest[i] = exp_dest[i];
                    sh_old[i]  = exp_old[i];
                end
                if (dec_vld[i] && dec_src1_vld[i]) begin
                    sh_src1[i] = exp_src1[i];
                end
                if (dec_vld[i] && dec_src2_vld[i]) begin
                    sh_src2[i] = exp_src2[i];
                end
                sh_src1_en[i] = dec_vld[i] && dec_src1_vld[i];
                sh_src2_en[i] = dec_vld[i] && dec_src2_vld[i];
            end
        end
    endtask

    task automatic check_comb();
        assert (alloc_en == exp_alloc) else report_mismatch("alloc_en", alloc_en, exp_alloc);
        assert (rat_wr_en == exp_wr) else report_mismatch("rat_wr_en", rat_wr_en, exp_wr);
        assert (dest_preg == exp_dest) else report_mismatch("dest_preg", dest_preg, exp_dest);
        assert (pr_num_need == exp_need)
            else report_mismatch("pr_num_need", pr_num_need, exp_need);
        assert (pause == exp_pause) else report_mismatch("pause", pause, exp_pause);
    endtask

    task automatic check_stage();
        assert (s4_dest_preg == sh_dest) else report_mismatch("s4_dest_preg", s4_dest_preg, sh_dest);
        assert (s4_old_preg == sh_old) else report_mismatch("s4_old_preg", s4_old_preg, sh_old);
        assert (s4_src1_preg == sh_src1) else report_mismatch("s4_src1_preg", s4_src1_preg, sh_src1);
        assert (s4_src2_preg == sh_src2) else report_mismatch("s4_src2_preg", s4_src2_preg, sh_src2);
        assert (s4_src1_en == sh_src1_en) else report_mismatch("s4_src1_en", s4_src1_en, sh_src1_en);
        assert (s4_src2_en == sh_src2_en) else report_mismatch("s4_src2_en", s4_src2_en, sh_src2_en);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        assert (cycle_cnt < TIMEOUT_CYCLES)
            else fail_run($sformatf("timeout: run did not end within %0d cycles",
                                    TIMEOUT_CYCLES));
    end

    initial begin
        lfsr_state = LFSR_SEED;
        flush = 1'b0; hold = 1'b0;
        dec_vld = '0; dec_dest_vld = '0; dec_src1_vld = '0; dec_src2_vld = '0;
        dec_dest_areg = '0; dec_src1_areg = '0; dec_src2_areg = '0;
        free_preg = '0; freelist_room = '0; rat_map = '0;
        exp_alloc = '0; exp_wr = '0; exp_need = '0; exp_pause = 1'b0;
        exp_dest = '0; exp_old = '0; exp_src1 = '0; exp_src2 = '0;
        sh_dest = '0; sh_old = '0; sh_src1 = '0; sh_src2 = '0;
        sh_src1_en = '0; sh_src2_en = '0;
        wait (rst_n === 1'b1);
        check_stage();   // reset values
        @(posedge clk);
        #10;
        for (int c = 0; c < NUM_CYCLES; c++) begin
            drive_inputs();
            compute_expected();
            #40;
            check_comb();   // mid-cycle, inputs settled
            @(posedge clk);
            update_shadow();
            #5;
            check_stage();
            #5;
        end
        $display("cycles %0d, flush %0d, hold %0d, pause-driven hold %0d",
                 NUM_CYCLES, n_flush, n_hold, n_pause);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== rename.f ====
+incdir+rtl
rtl/rename_arch_pkg.sv
rtl/rename_ctrl_pkg.sv
rtl/rename_alloc.sv
rtl/rename_lookup.sv
rtl/rename_stage_reg.sv
rtl/rename_top.sv
tb/tb_clock_gen.sv
tb/rename_tb.sv
